/* hw/dbg_pkg.sv */
package dbg_pkg;

   ////////////////////////////////////////
   // Widths and depths
   ////////////////////////////////////////

   // Register width
   localparam int word_w = 32;
   // Instruction word as shifted in on mosi
   localparam int instr_w = 25;
   // Register select, sixteen registers
   localparam int sel_w = 4;
   localparam int num_regs = 2 ** sel_w;
   // Command queue depth
   localparam int fifo_depth = 8;

   ////////////////////////////////////////
   // Instruction fields
   ////////////////////////////////////////

   localparam int op_w    = 3;
   localparam int op_msb  = 24;
   localparam int op_lsb  = 22;
   localparam int rd_msb  = 21;
   localparam int rd_lsb  = 18;
   localparam int rs_msb  = 17;
   localparam int rs_lsb  = 14;
   localparam int imm_w   = 14;
   localparam int imm_msb = 13;
   localparam int imm_lsb = 0;
   // Second source inside imm, register-register ops only
   localparam int rt_msb  = 3;
   localparam int rt_lsb  = 0;
   // Shift amount inside imm
   localparam int sh_w    = 5;
   localparam int sh_msb  = 4;
   localparam int sh_lsb  = 0;

   // Opcodes, 5 and 6 are no-ops
   localparam logic [op_w-1:0] op_addi = 3'd0;
   localparam logic [op_w-1:0] op_add  = 3'd1;
   localparam logic [op_w-1:0] op_sub  = 3'd2;
   localparam logic [op_w-1:0] op_xor  = 3'd3;
   localparam logic [op_w-1:0] op_shl  = 3'd4;
   localparam logic [op_w-1:0] op_halt = 3'd7;

   // Queue payload
   typedef logic [instr_w-1:0] instr_t;

endpackage

/* hw/dbg_cmd_capture.sv */
`timescale 1ns/1ps

module dbg_cmd_capture (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        sclk,
   input  logic [dbg_pkg::instr_w-1:0] mosi,
   input  logic                        cmd_ready,
   output logic                        cmd_valid,
   output logic [dbg_pkg::instr_w-1:0] cmd_data,
   output logic                        overrun
);

   // Strobe synchronizer plus one flop for edge detection
   logic                        sclk_s1;
   logic                        sclk_s2;
   logic                        sclk_s3;
   // Data synchronizer
   logic [dbg_pkg::instr_w-1:0] mosi_s1;
   logic [dbg_pkg::instr_w-1:0] mosi_s2;
   // Rising edge, raw and registered
   logic                        sclk_rise;
   logic                        sclk_rise_q;

   ////////////////////////////////////////
   // Synchronizers and edge detect
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sclk_s1     <= 1'b0;
         sclk_s2     <= 1'b0;
         sclk_s3     <= 1'b0;
         sclk_rise_q <= 1'b0;
      end else begin
         sclk_s1     <= sclk;
         sclk_s2     <= sclk_s1;
         sclk_s3     <= sclk_s2;
         sclk_rise_q <= sclk_rise;
      end
   end

   // Data path, sampled alongside the strobe
   always_ff @(posedge clk) begin
      mosi_s1 <= mosi;
      mosi_s2 <= mosi_s1;
   end

   // High for one cycle on a synchronized low-to-high
   assign sclk_rise = sclk_s2 & ~sclk_s3;

   ////////////////////////////////////////
   // Holding register
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cmd_valid <= 1'b0;
         overrun   <= 1'b0;
      end else if (sclk_rise_q) begin
         // Held word still waiting, drop the new one
         if (cmd_valid && !cmd_ready) begin
            overrun <= 1'b1;
         end else begin
            cmd_valid <= 1'b1;
         end
      end else if (cmd_ready) begin
         cmd_valid <= 1'b0;
      end
   end

   // Word loads whenever the slot is free or draining this cycle
   always_ff @(posedge clk) begin
      if (sclk_rise_q && (!cmd_valid || cmd_ready)) begin
         cmd_data <= mosi_s2;
      end
   end

endmodule

/* hw/dbg_fifo.sv */
`timescale 1ns/1ps

module dbg_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  depth     = 4
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     in_valid,
   input  payload_t in_data,
   input  logic     out_ready,
   output logic     in_ready,
   output logic     out_valid,
   output payload_t out_data
);

   // Pointer and count sizing, depth need not be a power of two
   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int cnt_w = $clog2(depth + 1);
   localparam logic [ptr_w-1:0] last_ptr = ptr_w'(depth - 1);
   localparam logic [cnt_w-1:0] full_cnt = cnt_w'(depth);

   payload_t         mem [depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;
   logic             push;
   logic             pop;

   // Handshakes on both sides
   assign in_ready  = (count != full_cnt);
   assign out_valid = (count != '0);
   assign push      = in_valid & in_ready;
   assign pop       = out_valid & out_ready;

   // Head of queue, read straight from storage
   assign out_data = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_data;
      end
   end

   ////////////////////////////////////////
   // Pointers and occupancy
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
         end
         // Simultaneous push and pop leaves count alone
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

/* hw/dbg_core.sv */
`timescale 1ns/1ps

module dbg_core (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        exe_valid,
   input  logic [dbg_pkg::instr_w-1:0] exe_data,
   input  logic                        step,
   input  logic                        resume,
   input  logic [dbg_pkg::sel_w-1:0]   rd_sel,
   output logic                        exe_ready,
   output logic [dbg_pkg::word_w-1:0]  miso,
   output logic                        halt
);

   // Control pin synchronizers and edge detect
   logic                        step_s1;
   logic                        step_s2;
   logic                        step_s3;
   logic                        step_rise_q;
   logic                        resume_s1;
   logic                        resume_s2;
   logic                        resume_s3;
   logic                        resume_rise_q;
   // One pending step while halted
   logic                        credit;
   logic                        accept;
   // Decoded fields
   logic [dbg_pkg::op_w-1:0]    opcode;
   logic [dbg_pkg::sel_w-1:0]   rd;
   logic [dbg_pkg::sel_w-1:0]   rs;
   logic [dbg_pkg::sel_w-1:0]   rt;
   logic [dbg_pkg::imm_w-1:0]   imm;
   logic [dbg_pkg::sh_w-1:0]    shamt;
   logic [dbg_pkg::word_w-1:0]  imm_ext;
   logic [dbg_pkg::word_w-1:0]  rs_val;
   logic [dbg_pkg::word_w-1:0]  rt_val;
   logic [dbg_pkg::word_w-1:0]  result;
   logic                        wr_en;
   // Register file, entry 0 never written
   logic [dbg_pkg::word_w-1:0]  regs [dbg_pkg::num_regs];

   ////////////////////////////////////////
   // Step and resume edges
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         step_s1       <= 1'b0;
         step_s2       <= 1'b0;
         step_s3       <= 1'b0;
         step_rise_q   <= 1'b0;
         resume_s1     <= 1'b0;
         resume_s2     <= 1'b0;
         resume_s3     <= 1'b0;
         resume_rise_q <= 1'b0;
      end else begin
         step_s1       <= step;
         step_s2       <= step_s1;
         step_s3       <= step_s2;
         step_rise_q   <= step_s2 & ~step_s3;
         resume_s1     <= resume;
         resume_s2     <= resume_s1;
         resume_s3     <= resume_s2;
         resume_rise_q <= resume_s2 & ~resume_s3;
      end
   end

   // Running, or halted with a step granted
   assign exe_ready = ~halt | credit;
   assign accept    = exe_valid & exe_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         halt   <= 1'b0;
         credit <= 1'b0;
      end else begin
         // Halt instruction wins over a same-cycle resume
         if (accept && opcode == dbg_pkg::op_halt) begin
            halt <= 1'b1;
         end else if (resume_rise_q) begin
            halt <= 1'b0;
         end
         // Credit saturates at one, only meaningful while halted
         if (resume_rise_q || !halt) begin
            credit <= 1'b0;
         end else if (step_rise_q) begin
            credit <= 1'b1;
         end else if (accept) begin
            credit <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////
   // Decode and execute
   ////////////////////////////////////////

   assign opcode  = exe_data[dbg_pkg::op_msb:dbg_pkg::op_lsb];
   assign rd      = exe_data[dbg_pkg::rd_msb:dbg_pkg::rd_lsb];
   assign rs      = exe_data[dbg_pkg::rs_msb:dbg_pkg::rs_lsb];
   assign imm     = exe_data[dbg_pkg::imm_msb:dbg_pkg::imm_lsb];
   assign rt      = imm[dbg_pkg::rt_msb:dbg_pkg::rt_lsb];
   assign shamt   = imm[dbg_pkg::sh_msb:dbg_pkg::sh_lsb];
   assign imm_ext = {{(dbg_pkg::word_w - dbg_pkg::imm_w){1'b0}}, imm};
   assign rs_val  = regs[rs];
   assign rt_val  = regs[rt];

   always_comb begin
      result = '0;
      wr_en  = 1'b1;
      case (opcode)
         dbg_pkg::op_addi: result = rs_val + imm_ext;
         dbg_pkg::op_add:  result = rs_val + rt_val;
         dbg_pkg::op_sub:  result = rs_val - rt_val;
         dbg_pkg::op_xor:  result = rs_val ^ rt_val;
         dbg_pkg::op_shl:  result = rs_val << shamt;
         // Halt and the spare codes write nothing
         default:          wr_en  = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < dbg_pkg::num_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (accept && wr_en && rd != '0) begin
         regs[rd] <= result;
      end
   end

   // Readback port
   assign miso = regs[rd_sel];

endmodule

/* hw/dbg_top.sv */
`timescale 1ns/1ps

module dbg_top (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        sclk,
   input  logic [dbg_pkg::instr_w-1:0] mosi,
   input  logic                        step,
   input  logic                        resume,
   input  logic [dbg_pkg::sel_w-1:0]   rd_sel,
   output logic [dbg_pkg::word_w-1:0]  miso,
   output logic                        halt,
   output logic                        overrun
);

   // Capture to queue
   logic            cmd_valid;
   logic            cmd_ready;
   dbg_pkg::instr_t cmd_data;
   // Queue to core
   logic            exe_valid;
   logic            exe_ready;
   dbg_pkg::instr_t exe_data;

   dbg_cmd_capture capture_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .sclk      (sclk),
      .mosi      (mosi),
      .cmd_ready (cmd_ready),
      .cmd_valid (cmd_valid),
      .cmd_data  (cmd_data),
      .overrun   (overrun)
   );

   dbg_fifo #(
      .payload_t (dbg_pkg::instr_t),
      .depth     (dbg_pkg::fifo_depth)
   ) fifo_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (cmd_valid),
      .in_data   (cmd_data),
      .out_ready (exe_ready),
      .in_ready  (cmd_ready),
      .out_valid (exe_valid),
      .out_data  (exe_data)
   );

   dbg_core core_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .exe_valid (exe_valid),
      .exe_data  (exe_data),
      .step      (step),
      .resume    (resume),
      .rd_sel    (rd_sel),
      .exe_ready (exe_ready),
      .miso      (miso),
      .halt      (halt)
   );

endmodule

/* tests/tb_dbg_util.svh */
`ifndef TB_DBG_UTIL_SVH
`define TB_DBG_UTIL_SVH

////////////////////////////////////////
// Stimulus generation
////////////////////////////////////////

// Classic 32-bit LCG constants
function automatic logic [31:0] lcg_next();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

// Any opcode but halt with fields from upper LCG bits
function automatic dbg_pkg::instr_t rand_instr();
   logic [31:0]     a;
   logic [31:0]     b;
   dbg_pkg::instr_t w;
   a = lcg_next();
   b = lcg_next();
   w = '0;
   w[dbg_pkg::op_msb:dbg_pkg::op_lsb]   = 3'(a[31:16] % 16'd7);
   w[dbg_pkg::rd_msb:dbg_pkg::rd_lsb]   = b[31:28];
   w[dbg_pkg::rs_msb:dbg_pkg::rs_lsb]   = b[27:24];
   w[dbg_pkg::imm_msb:dbg_pkg::imm_lsb] = b[23:10];
   return w;
endfunction

// Odd imm added to rd so the target always changes
function automatic dbg_pkg::instr_t step_instr();
   logic [31:0]     r;
   dbg_pkg::instr_t w;
   r = lcg_next();
   w = '0;
   w[dbg_pkg::op_msb:dbg_pkg::op_lsb]   = dbg_pkg::op_addi;
   w[dbg_pkg::rd_msb:dbg_pkg::rd_lsb]   = (r[31:28] == 4'd0) ? 4'd1 : r[31:28];
   w[dbg_pkg::rs_msb:dbg_pkg::rs_lsb]   = w[dbg_pkg::rd_msb:dbg_pkg::rd_lsb];
   w[dbg_pkg::imm_msb:dbg_pkg::imm_lsb] = {r[23:11], 1'b1};
   return w;
endfunction

////////////////////////////////////////
// Reference model
////////////////////////////////////////

function automatic void model_apply(input dbg_pkg::instr_t w);
   logic [dbg_pkg::op_w-1:0]   op;
   logic [dbg_pkg::sel_w-1:0]  rd;
   logic [dbg_pkg::imm_w-1:0]  imm;
   logic [dbg_pkg::word_w-1:0] a;
   logic [dbg_pkg::word_w-1:0] b;
   logic [dbg_pkg::word_w-1:0] res;
   op  = w[dbg_pkg::op_msb:dbg_pkg::op_lsb];
   rd  = w[dbg_pkg::rd_msb:dbg_pkg::rd_lsb];
   imm = w[dbg_pkg::imm_msb:dbg_pkg::imm_lsb];
   a   = model_regs[w[dbg_pkg::rs_msb:dbg_pkg::rs_lsb]];
   // rt lives in the low imm bits
   b   = model_regs[imm[dbg_pkg::rt_msb:dbg_pkg::rt_lsb]];
   res = model_regs[rd];
   case (op)
      dbg_pkg::op_addi: res = a + {18'd0, imm};
      dbg_pkg::op_add:  res = a + b;
      dbg_pkg::op_sub:  res = a - b;
      dbg_pkg::op_xor:  res = a ^ b;
      dbg_pkg::op_shl:  res = a << imm[dbg_pkg::sh_msb:dbg_pkg::sh_lsb];
      default:          res = model_regs[rd];
   endcase
   // r0 is hardwired
   if (rd != 4'd0) begin
      model_regs[rd] = res;
   end
endfunction

////////////////////////////////////////
// Checks and bounded waits
////////////////////////////////////////

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
   if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      test_errs++;
   end
endtask

// Polls halt or miso at falling edges
task automatic wait_for_value(input bit use_miso, input logic [31:0] exp);
   logic [31:0] cur;
   int          n;
   n = 0;
   do begin
      @(negedge clk);
      cur = use_miso ? miso : 32'(halt);
      n++;
   end while (cur !== exp && n < wait_limit);
   if (cur !== exp) begin
      $display("timeout: %s did not reach %h", use_miso ? "miso" : "halt", exp);
      test_errs++;
   end
endtask

`endif

/* tests/tb_dbg_top.sv */
`timescale 1ns/1ps

module tb_dbg_top;

   localparam int wait_limit = 300;

   logic                        clk;
   logic                        rst_n;
   logic                        sclk;
   logic [dbg_pkg::instr_w-1:0] mosi;
   logic                        step;
   logic                        resume;
   logic [dbg_pkg::sel_w-1:0]   rd_sel;
   logic [dbg_pkg::word_w-1:0]  miso;
   logic                        halt;
   logic                        overrun;
   // Model state and test counters
   logic [dbg_pkg::word_w-1:0]  model_regs [dbg_pkg::num_regs];
   logic [31:0]                 lcg_state;
   int                          test_errs;
   int                          n_pass;
   int                          n_fail;
   // Readback select owned by the sweep or by the main sequence
   int                          sweep_req;
   int                          sweep_ack;
   logic [dbg_pkg::sel_w-1:0]   sweep_sel;
   logic [dbg_pkg::sel_w-1:0]   watch_sel;

   `include "tb_dbg_util.svh"

   dbg_top dbg_top_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .sclk    (sclk),
      .mosi    (mosi),
      .step    (step),
      .resume  (resume),
      .rd_sel  (rd_sel),
      .miso    (miso),
      .halt    (halt),
      .overrun (overrun)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   assign rd_sel = (sweep_ack != sweep_req) ? sweep_sel : watch_sel;

   ////////////////////////////////////////
   // Register sweep against the model
   ////////////////////////////////////////

   initial begin
      sweep_ack = 0;
      sweep_sel = '0;
      forever begin
         @(posedge clk);
         if (sweep_ack != sweep_req) begin
            for (int i = 0; i < dbg_pkg::num_regs; i++) begin
               #2;
               sweep_sel = 4'(i);
               // Mid-cycle sample away from register updates
               @(negedge clk);
               check_value($sformatf("miso r%0d", i), miso, model_regs[i]);
               @(posedge clk);
            end
            #2;
            sweep_ack = sweep_req;
         end
      end
   end

   task automatic sweep_regs();
      int n;
      @(posedge clk);
      #2;
      sweep_req++;
      n = 0;
      while (sweep_ack != sweep_req && n < wait_limit) begin
         @(negedge clk);
         n++;
      end
      if (sweep_ack != sweep_req) begin
         $display("timeout: register sweep did not complete");
         test_errs++;
      end
   endtask

   // Word leads the strobe by two cycles and outlasts it
   task automatic send_word(input dbg_pkg::instr_t w);
      @(posedge clk);
      #2;
      mosi = w;
      repeat (2) @(posedge clk);
      #2;
      sclk = 1'b1;
      repeat (4) @(posedge clk);
      #2;
      sclk = 1'b0;
      repeat (4) @(posedge clk);
   endtask

   task automatic pulse_control(input bit is_step);
      @(posedge clk);
      #2;
      step   = is_step;
      resume = !is_step;
      repeat (4) @(posedge clk);
      #2;
      step   = 1'b0;
      resume = 1'b0;
      repeat (4) @(posedge clk);
   endtask

   task automatic check_flags(input logic exp_halt, input logic exp_overrun);
      @(negedge clk);
      check_value("halt", 32'(halt), 32'(exp_halt));
      check_value("overrun", 32'(overrun), 32'(exp_overrun));
   endtask

   task automatic finish_test(input string name);
      if (test_errs == 0) begin
         $display("PASS %s", name);
         n_pass++;
      end else begin
         $display("FAIL %s, %0d errors", name, test_errs);
         n_fail++;
      end
      test_errs = 0;
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial begin
      dbg_pkg::instr_t pending [$];
      dbg_pkg::instr_t w;
      dbg_pkg::instr_t halt_word;
      rst_n     = 1'b0;
      sclk      = 1'b0;
      mosi      = '0;
      step      = 1'b0;
      resume    = 1'b0;
      watch_sel = '0;
      sweep_req = 0;
      lcg_state = 32'hc7a11f0e;
      test_errs = 0;
      n_pass    = 0;
      n_fail    = 0;
      for (int i = 0; i < dbg_pkg::num_regs; i++) begin
         model_regs[i] = '0;
      end
      halt_word = '0;
      halt_word[dbg_pkg::op_msb:dbg_pkg::op_lsb] = dbg_pkg::op_halt;
      repeat (3) @(posedge clk);
      #2;
      rst_n = 1'b1;

      check_flags(1'b0, 1'b0);
      sweep_regs();
      finish_test("reset state");

      // Random program with r0 kept at zero in the model
      repeat (40) begin
         w = rand_instr();
         model_apply(w);
         send_word(w);
      end
      send_word(halt_word);
      wait_for_value(1'b0, 32'd1);
      sweep_regs();
      finish_test("random program then halt");

      // Queue four while halted and step through two
      repeat (4) begin
         w = step_instr();
         pending.push_back(w);
         send_word(w);
      end
      repeat (2) begin
         w = pending.pop_front();
         model_apply(w);
         @(posedge clk);
         #2;
         watch_sel = w[dbg_pkg::rd_msb:dbg_pkg::rd_lsb];
         pulse_control(1'b1);
         wait_for_value(1'b1, model_regs[watch_sel]);
         sweep_regs();
         check_flags(1'b1, 1'b0);
      end
      finish_test("single step while halted");

      // Resume drains the rest and a trailing halt marks the empty queue
      pulse_control(1'b0);
      wait_for_value(1'b0, 32'd0);
      while (pending.size() > 0) begin
         model_apply(pending.pop_front());
      end
      send_word(halt_word);
      wait_for_value(1'b0, 32'd1);
      sweep_regs();
      finish_test("resume drains queue");

      // Only queue depth plus the held word survive
      for (int i = 0; i < 14; i++) begin
         w = rand_instr();
         if (i < dbg_pkg::fifo_depth + 1) begin
            model_apply(w);
         end
         send_word(w);
      end
      check_flags(1'b1, 1'b1);
      pulse_control(1'b0);
      wait_for_value(1'b0, 32'd0);
      check_flags(1'b0, 1'b1);
      send_word(halt_word);
      wait_for_value(1'b0, 32'd1);
      sweep_regs();
      check_flags(1'b1, 1'b1);
      finish_test("overrun while halted");

      $display("tests: %0d passed, %0d failed", n_pass, n_fail);
      if (n_fail == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

/* project.f */
+incdir+tests
hw/dbg_pkg.sv
hw/dbg_cmd_capture.sv
hw/dbg_fifo.sv
hw/dbg_core.sv
hw/dbg_top.sv
tests/tb_dbg_top.sv

/* run.sh */
#!/bin/sh
# Build and run the debug link testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps -f project.f \
      --top-module tb_dbg_top -o tb_dbg_top; then
   echo "verilator build failed"
   exit 1
fi

if ! out=$(./obj_dir/tb_dbg_top); then
   echo "$out"
   echo "simulation exited with an error"
   exit 1
fi
echo "$out"

if echo "$out" | grep -qF 'All tests passed!'; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1
